/* aprDevice.f */
rtl/aprPkg.sv
rtl/aprFlagRegs.sv
rtl/aprEnableReg.sv
rtl/aprIntrReq.sv
rtl/aprDevice.sv
verif/aprDevice_asserts.sv
verif/aprDeviceTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the APR device simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/10ps \
   --top-module aprDeviceTb \
   -f aprDevice.f \
   -o aprDeviceSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/aprDeviceSim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

echo "Simulation finished with status 0"
exit 0

/* verif/aprDeviceTb.sv */
// Table-driven testbench for the APR status device with a reference model of the flag rules
`timescale 1ns/10ps
`default_nettype none

module aprDeviceTb
   import aprPkg::*;
;

   // One table row with stimulus and then expected outputs
   typedef struct packed
   {
      logic       clken;
      cromWord_t  crom;
      dataPath_t  dp;
      logic       nxmIntr;
      logic       ks10Intr;
      aprStatus_t expFlags;
      piReq_t     expIntr;
   } tableRow_t;

   logic         clk;
   logic         rst;
   logic         clken;
   cromWord_t    crom;
   dataPath_t    dp;
   logic         nxmIntr;
   logic         ks10Intr;
   aprStatus_t   aprFlags;
   piReq_t       aprIntr;

   tableRow_t    rows[$];
   string        names[$];
   int           seed;
   // Reference state
   aprFlagBits_t modelFlags;
   aprEnable_t   modelEn;

   aprDevice uut
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .nxmIntr  (nxmIntr),
      .ks10Intr (ks10Intr),
      .aprFlags (aprFlags),
      .aprIntr  (aprIntr)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Reset held for 8 rising edges and released on a falling edge
   initial
   begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic cromWord_t makeCrom(input logic en, input specSel_t sel);
      return '{specEn: en, specSel: sel};
   endfunction

   // LOAD APR word with fields on bits 22 to 35
   function automatic dataPath_t enableWord(input logic trap, input logic page,
                                            input logic [7:0] flagEn, input logic sw,
                                            input logic [2:0] lvl);
      return {22'h0, trap, page, flagEn, sw, lvl};
   endfunction

   // Flags sit on bits 24 to 31
   function automatic dataPath_t flagWord(input logic [7:0] f);
      return {24'h0, f, 4'h0};
   endfunction

   task automatic abortRun();
      $display("Something failed");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic compareValue(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
      if (expected !== actual)
      begin
         $display("Mismatch %s expected %h actual %h", name, expected, actual);
         abortRun();
      end
   endtask

   // Append a row and advance the reference model by one clock
   task automatic addRow(input string name, input logic rowClken, input cromWord_t rowCrom,
                         input dataPath_t rowDp, input logic rowNxm, input logic rowKs10);
      tableRow_t row;
      logic      req;
      row.clken    = rowClken;
      row.crom     = rowCrom;
      row.dp       = rowDp;
      row.nxmIntr  = rowNxm;
      row.ks10Intr = rowKs10;
      if (rowClken && rowCrom.specEn && rowCrom.specSel == specAprFlags)
         modelFlags = rowDp[24:31];
      if (rowClken && rowCrom.specEn && rowCrom.specSel == specLoadApr)
         modelEn = rowDp[22:35];
      // Hardware sets ignore clken and beat the load
      if (rowNxm)
         modelFlags[27] = 1'b1;
      if (rowKs10)
         modelFlags[31] = 1'b1;
      req = modelEn.swInt;
      for (int b = 24; b <= 31; b++)
         if (modelFlags[b] && modelEn.flagEn[b])
            req = 1'b1;
      row.expFlags = {modelEn.trapEn, modelEn.pageEn, modelFlags, req, 3'b111};
      row.expIntr  = '0;
      if (req && modelEn.piLevel != 3'd0)
         row.expIntr[modelEn.piLevel] = 1'b1;
      rows.push_back(row);
      names.push_back(name);
   endtask

   task automatic buildTable();
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      addRow("flagsLoad", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'hA5), 1'b0, 1'b0);
      addRow("flagsNoClken", 1'b0, makeCrom(1'b1, specAprFlags), flagWord(8'h00), 1'b0, 1'b0);
      addRow("flagsNoSpecEn", 1'b1, makeCrom(1'b0, specAprFlags), flagWord(8'h00), 1'b0, 1'b0);
      addRow("flagsLoadPi", 1'b1, makeCrom(1'b1, specLoadPi), flagWord(8'h00), 1'b0, 1'b0);
      addRow("flagsClear", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h00), 1'b0, 1'b0);
      addRow("enTrapPage", 1'b1, makeCrom(1'b1, specLoadApr),
             enableWord(1'b1, 1'b1, 8'h00, 1'b0, 3'd3), 1'b0, 1'b0);
      addRow("enFlagNoReq", 1'b1, makeCrom(1'b1, specLoadApr),
             enableWord(1'b0, 1'b0, 8'h10, 1'b0, 3'd3), 1'b0, 1'b0);
      addRow("flagSetReq", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h10), 1'b0, 1'b0);
      addRow("flagMasked", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h01), 1'b0, 1'b0);
      // Software interrupt with every level in turn
      for (int lvl = 0; lvl < 8; lvl++)
         addRow($sformatf("levelSweep%0d", lvl), 1'b1, makeCrom(1'b1, specLoadApr),
                enableWord(1'b0, 1'b0, 8'h00, 1'b1, lvl[2:0]), 1'b0, 1'b0);
      // Hardware set sources
      addRow("enHardware", 1'b1, makeCrom(1'b1, specLoadApr),
             enableWord(1'b0, 1'b0, 8'h11, 1'b0, 3'd2), 1'b0, 1'b0);
      addRow("hwClear", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h00), 1'b0, 1'b0);
      addRow("nxmNoClken", 1'b0, makeCrom(1'b0, specNone), flagWord(8'h00), 1'b1, 1'b0);
      addRow("ks10NoClken", 1'b0, makeCrom(1'b0, specNone), flagWord(8'h00), 1'b0, 1'b1);
      addRow("setBeatsLoad", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h00), 1'b1, 1'b1);
      addRow("laterClear", 1'b1, makeCrom(1'b1, specAprFlags), flagWord(8'h00), 1'b0, 1'b0);
      for (int i = 0; i < 48; i++)
      begin
         r1 = $random(seed);
         r2 = $random(seed);
         r3 = $random(seed);
         addRow($sformatf("random%0d", i), r3[3],
                makeCrom(r3[4], specSel_t'(r3[7:5] % 3'd5)), {r1[3:0], r2},
                r3[2:0] == 3'd0, r3[10:8] == 3'd0);
      end
   endtask

   task automatic waitResetRelease();
      int cycles;
      cycles = 0;
      while (rst !== 1'b0)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > 20)
         begin
            $display("Timeout: reset still asserted after %0d cycles", cycles);
            abortRun();
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      seed       = 32'hc4fa50b3;
      clken      = 1'b0;
      crom       = makeCrom(1'b0, specNone);
      dp         = '0;
      nxmIntr    = 1'b0;
      ks10Intr   = 1'b0;
      modelFlags = '0;
      modelEn    = '0;
      buildTable();
      waitResetRelease();
      @(negedge clk);
      // Idle state shows only the trailing ones
      compareValue("resetStatus", 16'h0007, {2'b00, aprFlags});
      compareValue("resetIntr", 16'h0000, {9'h000, aprIntr});
      for (int i = 0; i < rows.size(); i++)
      begin
         clken    = rows[i].clken;
         crom     = rows[i].crom;
         dp       = rows[i].dp;
         nxmIntr  = rows[i].nxmIntr;
         ks10Intr = rows[i].ks10Intr;
         @(negedge clk);
         compareValue({names[i], " aprFlags"}, {2'b00, rows[i].expFlags}, {2'b00, aprFlags});
         compareValue({names[i], " aprIntr"}, {9'h000, rows[i].expIntr}, {9'h000, aprIntr});
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/aprDevice_asserts.sv */
// Concurrent property checks on the APR device outputs and register state
`timescale 1ns/10ps
`default_nettype none

module aprDeviceAsserts
   import aprPkg::*;
(
   input logic         clk,
   input logic         rst,
   input logic         nxmIntr,
   input aprFlagBits_t flags,
   input aprEnable_t   enables,
   input aprStatus_t   aprFlags,
   input piReq_t       aprIntr
);

   // Never more than one PI line
   oneLine: assert property (@(posedge clk) disable iff (rst) $onehot0(aprIntr))
      else $error("aprIntr has more than one line high");

   // Level zero keeps the lines quiet
   levelZeroQuiet: assert property (@(posedge clk) disable iff (rst)
      enables.piLevel == 3'd0 |-> aprIntr == '0)
      else $error("aprIntr active with level zero");

   trailingOnes: assert property (@(posedge clk) disable iff (rst) aprFlags.ones == 3'b111)
      else $error("trailing status bits not all ones");

   // NXM sets flag 27 on the next edge
   nxmSetsFlag: assert property (@(posedge clk) disable iff (rst) nxmIntr |=> flags[27])
      else $error("flag 27 not set after nxmIntr");

endmodule

bind aprDevice aprDeviceAsserts checks
(
   .clk      (clk),
   .rst      (rst),
   .nxmIntr  (nxmIntr),
   .flags    (flags),
   .enables  (enables),
   .aprFlags (aprFlags),
   .aprIntr  (aprIntr)
);

`default_nettype wire

/* rtl/aprDevice.sv */
// APR device top level joining the flag and enable registers to the request logic
`timescale 1ns/10ps
`default_nettype none

module aprDevice
   import aprPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clken,
   input  cromWord_t  crom,
   input  dataPath_t  dp,
   input  logic       nxmIntr,
   input  logic       ks10Intr,
   output aprStatus_t aprFlags,
   output piReq_t     aprIntr
);

   // Register state feeding the request block
   aprFlagBits_t flags;
   aprEnable_t   enables;

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////

   aprFlagRegs flagRegs
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .crom     (crom),
      .dp       (dp),
      .nxmIntr  (nxmIntr),
      .ks10Intr (ks10Intr),
      .flags    (flags)
   );

   aprEnableReg enableReg
   (
      .clk     (clk),
      .rst     (rst),
      .clken   (clken),
      .crom    (crom),
      .dp      (dp),
      .enables (enables)
   );

   ////////////////////////////////////////////////////////////
   // Request and status
   ////////////////////////////////////////////////////////////

   // Combinational, outputs follow register state directly
   aprIntrReq intrReq
   (
      .flags    (flags),
      .enables  (enables),
      .aprFlags (aprFlags),
      .aprIntr  (aprIntr)
   );

endmodule

`default_nettype wire

/* rtl/aprIntrReq.sv */
// APR interrupt request logic that masks flags, decodes the PI level and builds the status word
`timescale 1ns/10ps
`default_nettype none

module aprIntrReq
   import aprPkg::*;
(
   input  aprFlagBits_t flags,
   input  aprEnable_t   enables,
   output aprStatus_t   aprFlags,
   output piReq_t       aprIntr
);

   ////////////////////////////////////////////////////////////
   // Interrupt mask
   ////////////////////////////////////////////////////////////

   logic         intReq;
   aprFlagBits_t maskedFlags;

   // Only enabled flags can raise a request
   assign maskedFlags = flags & enables.flagEn;

   // Software interrupt requests regardless of the flags
   assign intReq = (|maskedFlags) || enables.swInt;

   ////////////////////////////////////////////////////////////
   // Level decode
   ////////////////////////////////////////////////////////////

   // One-hot onto the seven PI lines
   always_comb
   begin
      aprIntr = '0;
      if (intReq)
      begin
         case (enables.piLevel)
            3'd1:    aprIntr = 7'b1000000;
            3'd2:    aprIntr = 7'b0100000;
            3'd3:    aprIntr = 7'b0010000;
            3'd4:    aprIntr = 7'b0001000;
            3'd5:    aprIntr = 7'b0000100;
            3'd6:    aprIntr = 7'b0000010;
            3'd7:    aprIntr = 7'b0000001;
            // Level zero disables the request lines
            default: aprIntr = 7'b0000000;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Status word
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      aprFlags.trapEn = enables.trapEn;
      aprFlags.pageEn = enables.pageEn;
      // Raw flags, not the masked ones
      aprFlags.flags  = flags;
      aprFlags.intReq = intReq;
      // Bits 33 to 35 read back as ones
      aprFlags.ones   = 3'b111;
   end

endmodule

`default_nettype wire

/* rtl/aprEnableReg.sv */
// APR enable register loaded by microcode from data path bits 22 to 35
`timescale 1ns/10ps
`default_nettype none

module aprEnableReg
   import aprPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       clken,
   input  cromWord_t  crom,
   input  dataPath_t  dp,
   output aprEnable_t enables
);

   ////////////////////////////////////////////////////////////
   // Microcode decode
   ////////////////////////////////////////////////////////////

   logic       loadApr;
   aprEnable_t dpFields;

   // Write qualifier for the LOAD APR select
   assign loadApr = clken && crom.specEn && (crom.specSel == specLoadApr);

   // Field split of the big-endian data path word
   always_comb
   begin
      dpFields.trapEn  = dp[22];
      dpFields.pageEn  = dp[23];
      // Per-flag interrupt enables line up with flags 24 to 31
      dpFields.flagEn  = dp[24:31];
      dpFields.swInt   = dp[32];
      // Level 1 is the highest priority, 0 means no request
      dpFields.piLevel = dp[33:35];
   end

   ////////////////////////////////////////////////////////////
   // Enable register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         enables <= '0;
      end
      else if (loadApr)
      begin
         enables <= dpFields;
      end
   end

endmodule

`default_nettype wire

/* rtl/aprFlagRegs.sv */
// APR flag register holding the eight processor flags with microcode load and hardware set
`timescale 1ns/10ps
`default_nettype none

module aprFlagRegs
   import aprPkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         clken,
   input  cromWord_t    crom,
   input  dataPath_t    dp,
   input  logic         nxmIntr,
   input  logic         ks10Intr,
   output aprFlagBits_t flags
);

   ////////////////////////////////////////////////////////////
   // Microcode decode
   ////////////////////////////////////////////////////////////

   logic         loadFlags;
   aprFlagBits_t flagsNext;

   // Write qualifier for the APR flags select
   assign loadFlags = clken && crom.specEn && (crom.specSel == specAprFlags);

   ////////////////////////////////////////////////////////////
   // Flag update
   ////////////////////////////////////////////////////////////

   // Flag assignments
   //   24  software interrupt, microcode only
   //   25  interrupt to the console, microcode only
   //   26  power fail, source not implemented
   //   27  non-existent memory, hardware set
   //   28  uncorrectable memory error, source not implemented
   //   29  correctable memory error, source not implemented
   //   30  interval timer, managed by microcode
   //   31  console interrupt request, hardware set
   //
   // Unimplemented sources leave their flags software-writable only

   always_comb
   begin
      flagsNext = flags;

      // Microcode load of all eight flags
      if (loadFlags)
      begin
         flagsNext = dp[24:31];
      end

      // Hardware sets are sticky and win over the load
      if (nxmIntr)
      begin
         flagsNext[27] = 1'b1;
      end

      if (ks10Intr)
      begin
         flagsNext[31] = 1'b1;
      end
   end

   // Hardware sets do not wait for clken
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flags <= '0;
      end
      else
      begin
         flags <= flagsNext;
      end
   end

endmodule

`default_nettype wire

/* rtl/aprPkg.sv */
// KS-10 arithmetic processor status device types shared across the design
`default_nettype none

package aprPkg;

   ////////////////////////////////////////////////////////////
   // Data path
   ////////////////////////////////////////////////////////////

   // 36-bit word in PDP-10 order
   // Bit 0 is the most significant bit
   typedef logic [0:35] dataPath_t;

   ////////////////////////////////////////////////////////////
   // Microword subset
   ////////////////////////////////////////////////////////////

   // Special-function selects
   // Only the two APR selects matter to this device
   typedef enum logic [2:0]
   {
      specNone     = 3'd0,
      specLoadApr  = 3'd1,
      specAprFlags = 3'd2,
      specLoadPi   = 3'd3,
      specMemClr   = 3'd4
   } specSel_t;

   // Fields of the control word seen by the APR
   typedef struct packed
   {
      // Special field enabled
      logic     specEn;
      // Which special function
      specSel_t specSel;
   } cromWord_t;

   ////////////////////////////////////////////////////////////
   // APR state
   ////////////////////////////////////////////////////////////

   // Processor flags, data path bits 24 to 31
   typedef logic [24:31] aprFlagBits_t;

   // Enable register as laid out on data path bits 22 to 35
   typedef struct packed
   {
      logic         trapEn;
      logic         pageEn;
      aprFlagBits_t flagEn;
      logic         swInt;
      logic [2:0]   piLevel;
   } aprEnable_t;

   // Status word, bits 22 to 35
   typedef struct packed
   {
      logic         trapEn;
      logic         pageEn;
      aprFlagBits_t flags;
      logic         intReq;
      // Always reads as ones
      logic [2:0]   ones;
   } aprStatus_t;

   // Request lines to the PI system, level 1 first
   typedef logic [1:7] piReq_t;

endpackage

`default_nettype wire
